// ==== fpu_add_params.svh ====
`ifndef FPU_ADD_PARAMS_SVH
`define FPU_ADD_PARAMS_SVH

//////////////////////////////////////////////////////////////////////
// Working widths of the adder datapath
//////////////////////////////////////////////////////////////////////

// Hidden bit, fraction, then guard, round and sticky
`define FP_SWR 27
// Shift amount, enough for one full significand sweep
`define FP_EWR 5

//////////////////////////////////////////////////////////////////////
// IEEE single precision field widths
//////////////////////////////////////////////////////////////////////

`define FP_EXP_W 8
`define FP_MAN_W 23

`endif

// ==== fpu_add_pkg.sv ====
`include "fpu_add_params.svh"

package fpu_add_pkg;

  //////////////////////////////////////////////////////////////////////
  // Float word and shifter request
  //////////////////////////////////////////////////////////////////////

  // Single precision word, sign on top
  typedef struct packed {
    logic                 sign;
    logic [`FP_EXP_W-1:0] exp;
    logic [`FP_MAN_W-1:0] frac;
  } fp_word_t;

  // Direction select of the shared shifter
  typedef enum logic {
    SHIFT_RIGHT = 1'b0,
    SHIFT_LEFT  = 1'b1
  } shift_dir_e;

  // One shift job, 34 bits in all
  typedef struct packed {
    logic [`FP_SWR-1:0] data;
    logic [`FP_EWR-1:0] amount;
    shift_dir_e         dir;
    logic               fill;
  } shift_req_t;

  //////////////////////////////////////////////////////////////////////
  // Opcodes and control states
  //////////////////////////////////////////////////////////////////////

  typedef enum logic {
    OP_ADD = 1'b0,
    OP_SUB = 1'b1
  } fadd_op_e;

  // Sequencer states, one cycle each apart from idle
  typedef enum logic [2:0] {
    S_IDLE,
    S_ALIGN,
    S_ADD,
    S_NORM,
    S_PACK
  } fadd_state_e;

endpackage

// ==== bidir_shifter.sv ====
`timescale 1ns/100ps

`include "fpu_add_params.svh"

module bidir_shifter (
  input  fpu_add_pkg::shift_req_t shift_req_i,
  output logic [`FP_SWR-1:0]      data_o
);

  // Data plus one appended fill bit below it
  localparam int unsigned EW = `FP_SWR + 1;
  // Number of log stages
  localparam int unsigned SW = `FP_EWR;

  logic               left;
  logic [EW-1:0]      ext_word;
  logic [EW-1:0]      shifted;
  logic [SW:0][EW-1:0] stage;

  // Mirror the word end to end
  function automatic logic [EW-1:0] reverse_bits(input logic [EW-1:0] v);
    logic [EW-1:0] r;
    for (int i = 0; i < EW; i++) begin
      r[i] = v[EW-1-i];
    end
    return r;
  endfunction

  assign left     = (shift_req_i.dir == fpu_add_pkg::SHIFT_LEFT);
  assign ext_word = {shift_req_i.data, shift_req_i.fill};

  //////////////////////////////////////////////////////////////////////
  // Reverse, right shift, reverse
  //////////////////////////////////////////////////////////////////////

  // Left shift becomes a right shift on the mirrored word
  assign stage[0] = left ? reverse_bits(ext_word) : ext_word;

  // Stage k moves by 2**k, fill bit enters from the top
  for (genvar k = 0; k < SW; k++) begin : g_stage
    localparam int unsigned STEP = 1 << k;
    assign stage[k+1] = shift_req_i.amount[k] ?
                        {{STEP{shift_req_i.fill}}, stage[k][EW-1:STEP]} :
                        stage[k];
  end

  // Undo the mirror for left shifts
  assign shifted = left ? reverse_bits(stage[SW]) : stage[SW];

  // Drop the appended fill slot
  assign data_o = shifted[EW-1:1];

  // Sequencer must clamp the alignment distance
  always_comb begin
    if (!$isunknown(shift_req_i.amount)) begin
      assert (shift_req_i.amount <= `FP_SWR)
        else $error("bidir_shifter amount %0d above width", shift_req_i.amount);
    end
  end

endmodule

// ==== exp_compare.sv ====
`timescale 1ns/100ps

`include "fpu_add_params.svh"

module exp_compare (
  input  fpu_add_pkg::fp_word_t a_i,
  input  fpu_add_pkg::fp_word_t b_i,
  input  fpu_add_pkg::fadd_op_e op_i,
  output fpu_add_pkg::fp_word_t big_o,
  output fpu_add_pkg::fp_word_t small_o,
  output logic [`FP_EWR-1:0]    exp_diff_o,
  output logic                  sticky_o,
  output logic                  eff_sub_o
);

  localparam int unsigned SWR = `FP_SWR;
  localparam int unsigned EWR = `FP_EWR;
  localparam int unsigned MW  = `FP_MAN_W;
  // Guard, round and sticky slots below the fraction
  localparam int unsigned GRS = SWR - MW - 1;

  fpu_add_pkg::fp_word_t a_clean;
  fpu_add_pkg::fp_word_t b_clean;
  logic                  a_is_big;
  logic [`FP_EXP_W-1:0]  diff_full;
  logic [SWR-1:0]        small_sig;
  logic [2**EWR-1:0]     drop_mask;

  always_comb begin
    // Exponent zero means zero, fraction ignored
    a_clean = a_i;
    b_clean = b_i;
    if (a_i.exp == '0) a_clean.frac = '0;
    if (b_i.exp == '0) b_clean.frac = '0;
    // Subtract as add of the negated b
    if (op_i == fpu_add_pkg::OP_SUB) b_clean.sign = ~b_i.sign;

    // Order by magnitude, exponent first then fraction
    a_is_big = {a_clean.exp, a_clean.frac} >= {b_clean.exp, b_clean.frac};
    big_o    = a_is_big ? a_clean : b_clean;
    small_o  = a_is_big ? b_clean : a_clean;

    // Distance, saturated at the shifter range
    diff_full  = big_o.exp - small_o.exp;
    exp_diff_o = (|diff_full[`FP_EXP_W-1:EWR]) ? '1 : diff_full[EWR-1:0];

    // Bits that fall off the bottom during alignment
    small_sig = {|small_o.exp, small_o.frac, {GRS{1'b0}}};
    drop_mask = ~({(2**EWR){1'b1}} << exp_diff_o);
    sticky_o  = |(small_sig & drop_mask[SWR-1:0]);

    eff_sub_o = a_clean.sign ^ b_clean.sign;
  end

endmodule

// ==== sig_addsub.sv ====
`timescale 1ns/100ps

`include "fpu_add_params.svh"

module sig_addsub (
  input  logic [`FP_SWR-1:0] big_sig_i,
  input  logic [`FP_SWR-1:0] small_sig_i,
  input  logic               eff_sub_i,
  output logic [`FP_SWR:0]   sum_o
);

  localparam int unsigned SWR = `FP_SWR;

  // One extra bit on top for the carry
  logic [SWR:0] big_ext;
  logic [SWR:0] small_ext;
  logic [SWR:0] add_res;
  logic [SWR:0] sub_res;

  assign big_ext   = {1'b0, big_sig_i};
  assign small_ext = {1'b0, small_sig_i};

  //////////////////////////////////////////////////////////////////////
  // Magnitude add or subtract
  //////////////////////////////////////////////////////////////////////

  assign add_res = big_ext + small_ext;
  // Ordered operands, so no borrow out
  assign sub_res = big_ext - small_ext;

  assign sum_o = eff_sub_i ? sub_res : add_res;

  // Operand ordering upstream keeps the difference non negative
  always_comb begin
    if (!$isunknown({big_sig_i, small_sig_i, eff_sub_i}) && eff_sub_i) begin
      assert (small_sig_i <= big_sig_i)
        else $error("sig_addsub negative difference %h - %h", big_sig_i, small_sig_i);
    end
  end

endmodule

// ==== lead_zero_count.sv ====
`timescale 1ns/100ps

`include "fpu_add_params.svh"

module lead_zero_count (
  input  logic [`FP_SWR-1:0] value_i,
  output logic [`FP_EWR-1:0] count_o,
  output logic               zero_o
);

  localparam int unsigned SWR = `FP_SWR;
  localparam int unsigned EWR = `FP_EWR;

  //////////////////////////////////////////////////////////////////////
  // Priority encoder on the highest set bit
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    // All zero gives the full width
    count_o = EWR'(SWR);
    // Upward scan, last hit is the leading one
    for (int i = 0; i < SWR; i++) begin
      if (value_i[i]) begin
        count_o = EWR'(SWR - 1 - i);
      end
    end
  end

  // Exact cancellation
  assign zero_o = ~|value_i;

endmodule

// ==== fadd_sequencer.sv ====
`timescale 1ns/100ps

`include "fpu_add_params.svh"

module fadd_sequencer (
  input  logic                    clk,
  input  logic                    rst_n_i,
  input  logic                    start_i,
  input  fpu_add_pkg::fadd_op_e   op_i,
  input  fpu_add_pkg::fp_word_t   a_i,
  input  fpu_add_pkg::fp_word_t   b_i,
  input  fpu_add_pkg::fp_word_t   big_i,
  input  fpu_add_pkg::fp_word_t   small_i,
  input  logic [`FP_EWR-1:0]      exp_diff_i,
  input  logic                    sticky_i,
  input  logic                    eff_sub_i,
  input  logic [`FP_SWR-1:0]      shift_data_i,
  input  logic [`FP_SWR:0]        sum_i,
  input  logic [`FP_EWR-1:0]      lz_count_i,
  input  logic                    lz_zero_i,
  output fpu_add_pkg::fp_word_t   op_a_o,
  output fpu_add_pkg::fp_word_t   op_b_o,
  output fpu_add_pkg::fadd_op_e   op_o,
  output fpu_add_pkg::shift_req_t shift_req_o,
  output logic [`FP_SWR-1:0]      big_sig_o,
  output logic [`FP_SWR-1:0]      small_sig_o,
  output logic                    eff_sub_o,
  output logic [`FP_SWR-1:0]      norm_val_o,
  output fpu_add_pkg::fp_word_t   result_o,
  output logic                    busy_o,
  output logic                    done_o
);

  localparam int unsigned SWR    = `FP_SWR;
  localparam int unsigned EWR    = `FP_EWR;
  localparam int unsigned MW     = `FP_MAN_W;
  localparam int unsigned GRS    = SWR - MW - 1;
  // Two spare bits catch overflow and underflow
  localparam int unsigned EXP_XW = `FP_EXP_W + 2;
  localparam logic signed [EXP_XW-1:0] EXP_INF = (1 << `FP_EXP_W) - 1;

  fpu_add_pkg::fadd_state_e state_q;
  fpu_add_pkg::fp_word_t    op_a_q;
  fpu_add_pkg::fp_word_t    op_b_q;
  fpu_add_pkg::fadd_op_e    op_q;
  fpu_add_pkg::fp_word_t    result_q;
  fpu_add_pkg::fp_word_t    pack_word;
  logic                     done_q;
  logic [SWR-1:0]           big_sig_q;
  logic [SWR-1:0]           small_sig_q;
  logic [SWR-1:0]           norm_q;
  logic [SWR-1:0]           small_sig_full;
  logic [EWR-1:0]           align_amt;
  logic                     eff_sub_q;
  logic                     sign_q;
  logic                     zero_q;
  logic signed [EXP_XW-1:0] exp_q;

  //////////////////////////////////////////////////////////////////////
  // Shared shifter request
  //////////////////////////////////////////////////////////////////////

  assign small_sig_full = {|small_i.exp, small_i.frac, {GRS{1'b0}}};
  // Anything past the width shifts to zero, sticky covers the rest
  assign align_amt = (exp_diff_i > EWR'(SWR)) ? EWR'(SWR) : exp_diff_i;

  always_comb begin
    shift_req_o.data   = small_sig_full;
    shift_req_o.amount = '0;
    shift_req_o.dir    = fpu_add_pkg::SHIFT_RIGHT;
    shift_req_o.fill   = 1'b0;
    case (state_q)
      fpu_add_pkg::S_ALIGN: begin
        shift_req_o.amount = align_amt;
      end
      fpu_add_pkg::S_NORM: begin
        // Leading one back to the hidden bit position
        shift_req_o.data   = norm_q;
        shift_req_o.amount = lz_count_i;
        shift_req_o.dir    = fpu_add_pkg::SHIFT_LEFT;
      end
      default: begin
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Control FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q  <= fpu_add_pkg::S_IDLE;
      done_q   <= 1'b0;
      result_q <= '0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        fpu_add_pkg::S_IDLE:  if (start_i) state_q <= fpu_add_pkg::S_ALIGN;
        fpu_add_pkg::S_ALIGN: state_q <= fpu_add_pkg::S_ADD;
        fpu_add_pkg::S_ADD:   state_q <= fpu_add_pkg::S_NORM;
        fpu_add_pkg::S_NORM:  state_q <= fpu_add_pkg::S_PACK;
        fpu_add_pkg::S_PACK: begin
          state_q  <= fpu_add_pkg::S_IDLE;
          done_q   <= 1'b1;
          result_q <= pack_word;
        end
        default: state_q <= fpu_add_pkg::S_IDLE;
      endcase
    end
  end

  // Working registers, one step per state
  always_ff @(posedge clk) begin
    case (state_q)
      fpu_add_pkg::S_IDLE: begin
        if (start_i) begin
          op_a_q <= a_i;
          op_b_q <= b_i;
          op_q   <= op_i;
        end
      end
      fpu_add_pkg::S_ALIGN: begin
        big_sig_q   <= {|big_i.exp, big_i.frac, {GRS{1'b0}}};
        // Dropped bits folded into the LSB
        small_sig_q <= {shift_data_i[SWR-1:1], shift_data_i[0] | sticky_i};
        eff_sub_q   <= eff_sub_i;
        sign_q      <= big_i.sign;
        exp_q       <= {2'b00, big_i.exp};
      end
      fpu_add_pkg::S_ADD: begin
        if (sum_i[SWR]) begin
          // Carry out, keep top bits and fold the lost one
          norm_q <= {sum_i[SWR:2], sum_i[1] | sum_i[0]};
          exp_q  <= exp_q + 1'b1;
        end else begin
          norm_q <= sum_i[SWR-1:0];
        end
      end
      fpu_add_pkg::S_NORM: begin
        norm_q <= shift_data_i;
        exp_q  <= exp_q - {{(EXP_XW-EWR){1'b0}}, lz_count_i};
        zero_q <= lz_zero_i;
      end
      default: begin
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Pack with truncation
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    pack_word.sign = sign_q;
    pack_word.exp  = exp_q[`FP_EXP_W-1:0];
    pack_word.frac = norm_q[SWR-2 -: MW];
    // Cancellation or underflow gives +0
    if (zero_q || exp_q[EXP_XW-1] || (exp_q == '0)) begin
      pack_word = '0;
    end else if (exp_q >= EXP_INF) begin
      // Signed infinity
      pack_word.exp  = '1;
      pack_word.frac = '0;
    end
  end

  assign op_a_o      = op_a_q;
  assign op_b_o      = op_b_q;
  assign op_o        = op_q;
  assign big_sig_o   = big_sig_q;
  assign small_sig_o = small_sig_q;
  assign eff_sub_o   = eff_sub_q;
  assign norm_val_o  = norm_q;
  assign result_o    = result_q;
  assign done_o      = done_q;
  assign busy_o      = (state_q != fpu_add_pkg::S_IDLE);

  // Completion strobe lasts one cycle
  a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
    done_o |=> !done_o);

  // FSM always in a known state once out of reset
  a_state_known: assert property (@(posedge clk) disable iff (!rst_n_i)
    !$isunknown(state_q));

endmodule

// ==== fpu_add_top.sv ====
`timescale 1ns/100ps

`include "fpu_add_params.svh"

module fpu_add_top (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic                  start_i,
  input  fpu_add_pkg::fadd_op_e op_i,
  input  fpu_add_pkg::fp_word_t a_i,
  input  fpu_add_pkg::fp_word_t b_i,
  output fpu_add_pkg::fp_word_t result_o,
  output logic                  busy_o,
  output logic                  done_o
);

  // Latched operands toward the comparator
  fpu_add_pkg::fp_word_t    op_a;
  fpu_add_pkg::fp_word_t    op_b;
  fpu_add_pkg::fadd_op_e    op;
  // Comparator results
  fpu_add_pkg::fp_word_t    big_word;
  fpu_add_pkg::fp_word_t    small_word;
  logic [`FP_EWR-1:0]       exp_diff;
  logic                     sticky;
  logic                     eff_sub_cmp;
  // Shifter, adder and counter paths
  fpu_add_pkg::shift_req_t  shift_req;
  logic [`FP_SWR-1:0]       shift_data;
  logic [`FP_SWR-1:0]       big_sig;
  logic [`FP_SWR-1:0]       small_sig;
  logic                     eff_sub_reg;
  logic [`FP_SWR:0]         sum;
  logic [`FP_SWR-1:0]       norm_val;
  logic [`FP_EWR-1:0]       lz_count;
  logic                     lz_zero;

  fadd_sequencer u_seq (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .start_i      (start_i),
    .op_i         (op_i),
    .a_i          (a_i),
    .b_i          (b_i),
    .big_i        (big_word),
    .small_i      (small_word),
    .exp_diff_i   (exp_diff),
    .sticky_i     (sticky),
    .eff_sub_i    (eff_sub_cmp),
    .shift_data_i (shift_data),
    .sum_i        (sum),
    .lz_count_i   (lz_count),
    .lz_zero_i    (lz_zero),
    .op_a_o       (op_a),
    .op_b_o       (op_b),
    .op_o         (op),
    .shift_req_o  (shift_req),
    .big_sig_o    (big_sig),
    .small_sig_o  (small_sig),
    .eff_sub_o    (eff_sub_reg),
    .norm_val_o   (norm_val),
    .result_o     (result_o),
    .busy_o       (busy_o),
    .done_o       (done_o)
  );

  exp_compare u_cmp (
    .a_i        (op_a),
    .b_i        (op_b),
    .op_i       (op),
    .big_o      (big_word),
    .small_o    (small_word),
    .exp_diff_o (exp_diff),
    .sticky_o   (sticky),
    .eff_sub_o  (eff_sub_cmp)
  );

  // Shared by alignment and normalization
  bidir_shifter u_shift (
    .shift_req_i (shift_req),
    .data_o      (shift_data)
  );

  sig_addsub u_addsub (
    .big_sig_i   (big_sig),
    .small_sig_i (small_sig),
    .eff_sub_i   (eff_sub_reg),
    .sum_o       (sum)
  );

  lead_zero_count u_lzc (
    .value_i (norm_val),
    .count_o (lz_count),
    .zero_o  (lz_zero)
  );

endmodule

// ==== tb_fpu_add.sv ====
`timescale 1ns/100ps

module tb_fpu_add;

  // Directed and random operations, each well under 40 cycles
  localparam int N_OPS       = 215;
  localparam int RESET_CYC   = 8;
  localparam int CYCLE_LIMIT = N_OPS * 40 + RESET_CYC;

  logic                  clk;
  logic                  rst_n_i;
  logic                  start_i;
  fpu_add_pkg::fadd_op_e op_i;
  fpu_add_pkg::fp_word_t a_i;
  fpu_add_pkg::fp_word_t b_i;
  fpu_add_pkg::fp_word_t result_o;
  logic                  busy_o;
  logic                  done_o;

  int    fail_cnt;
  int    check_cnt;
  int    tests_run;
  int    cycle_cnt;
  int    test_fail0;
  string test_name;

  // Start that the DUT actually takes
  wire accepted = start_i && !busy_o;

  fpu_add_top DUT (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .start_i  (start_i),
    .op_i     (op_i),
    .a_i      (a_i),
    .b_i      (b_i),
    .result_o (result_o),
    .busy_o   (busy_o),
    .done_o   (done_o)
  );

  always #20 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Protocol checkers
  //////////////////////////////////////////////////////////////////////

  // done_o rises on the fourth edge after the start edge, seen on the fifth
  a_done_latency: assert property (@(posedge clk) disable iff (!rst_n_i)
    done_o == $past(accepted, 5))
    else begin
      $display("done_o out of step with the accepted start at %0t ns", $time);
      fail_cnt++;
    end

  // Busy covers align through pack
  a_busy_window: assert property (@(posedge clk) disable iff (!rst_n_i)
    busy_o == ($past(accepted, 1) || $past(accepted, 2) ||
               $past(accepted, 3) || $past(accepted, 4)))
    else begin
      $display("busy_o does not span the operation at %0t ns", $time);
      fail_cnt++;
    end

  // Run limit
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, DUT stopped answering", cycle_cnt);
      $display("Test failures found");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  // Exact sum on a 2^-150 grid, then truncate
  function automatic logic [31:0] ref_add(input logic [31:0] a, input logic [31:0] b,
                                          input fpu_add_pkg::fadd_op_e op);
    logic [299:0] ma;
    logic [299:0] mb;
    logic [299:0] mag;
    logic         sa;
    logic         sb;
    logic         rs;
    int           p;
    int           re;
    sa = a[31];
    sb = b[31] ^ (op == fpu_add_pkg::OP_SUB);
    ma = '0;
    mb = '0;
    // Exponent 0 stays zero
    if (a[30:23] != 8'd0) ma = {276'd0, 1'b1, a[22:0]} << a[30:23];
    if (b[30:23] != 8'd0) mb = {276'd0, 1'b1, b[22:0]} << b[30:23];
    if (sa == sb) begin
      mag = ma + mb;
      rs  = sa;
    end else if (ma >= mb) begin
      mag = ma - mb;
      rs  = sa;
    end else begin
      mag = mb - ma;
      rs  = sb;
    end
    p = -1;
    for (int i = 0; i < 300; i++) begin
      if (mag[i]) p = i;
    end
    re = p - 23;
    // Cancellation and underflow give +0
    if (p < 0 || re <= 0) return 32'd0;
    if (re >= 255) return {rs, 8'hFF, 23'd0};
    mag = mag >> (p - 23);
    return {rs, re[7:0], mag[22:0]};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Stimulus and checking tasks
  //////////////////////////////////////////////////////////////////////

  task automatic wait_done();
    @(negedge clk);
    while (!done_o) @(negedge clk);
  endtask

  task automatic check_result(input logic [31:0] want);
    check_cnt++;
    assert (result_o === want)
      else begin
        $display("[FAIL] %0t ns result_o got %h expected %h", $time, {result_o}, want);
        fail_cnt++;
      end
  endtask

  // Launch one operation from idle
  task automatic issue_op(input logic [31:0] a, input logic [31:0] b,
                          input fpu_add_pkg::fadd_op_e op);
    @(posedge clk);
    start_i <= 1'b1;
    a_i     <= a;
    b_i     <= b;
    op_i    <= op;
    @(posedge clk);
    start_i <= 1'b0;
  endtask

  task automatic run_op(input logic [31:0] a, input logic [31:0] b,
                        input fpu_add_pkg::fadd_op_e op);
    issue_op(a, b, op);
    wait_done();
    check_result(ref_add(a, b, op));
  endtask

  task automatic begin_test(input string name);
    test_name  = name;
    test_fail0 = fail_cnt;
  endtask

  task automatic end_test();
    tests_run++;
    $display("%-16s %s, %0d failures", test_name,
             (fail_cnt == test_fail0) ? "ok" : "FAILED", fail_cnt - test_fail0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int                    ea;
    int                    eb;
    logic [31:0]           ra;
    logic [31:0]           rb;
    logic [31:0]           want;
    fpu_add_pkg::fadd_op_e rop;
    void'($urandom(32'h2dca));
    clk       = 1'b0;
    rst_n_i   = 1'b0;
    start_i   = 1'b0;
    op_i      = fpu_add_pkg::OP_ADD;
    a_i       = '0;
    b_i       = '0;
    fail_cnt  = 0;
    check_cnt = 0;
    tests_run = 0;
    cycle_cnt = 0;
    repeat (RESET_CYC) @(posedge clk);
    rst_n_i <= 1'b1;

    begin_test("reset");
    @(negedge clk);
    check_result(32'd0);
    assert (!busy_o && !done_o)
      else begin
        $display("busy_o or done_o still high after reset");
        fail_cnt++;
      end
    end_test();

    // Carry out and sticky fold
    begin_test("add_carry");
    run_op(32'h3FC00000, 32'h3FC00000, fpu_add_pkg::OP_ADD);
    run_op(32'h3FA00000, 32'h3FE00000, fpu_add_pkg::OP_ADD);
    run_op(32'h3F800001, 32'h3F800002, fpu_add_pkg::OP_ADD);
    end_test();

    // Left normalize through the shared shifter
    begin_test("cancel");
    run_op(32'h3F800001, 32'h3F800000, fpu_add_pkg::OP_SUB);
    run_op(32'hC0000003, 32'hBFFFFFFE, fpu_add_pkg::OP_SUB);
    end_test();

    // 1.0 and 2^-30
    begin_test("far_align");
    run_op(32'h3F800000, 32'h30800000, fpu_add_pkg::OP_SUB);
    run_op(32'h3F800000, 32'h30800000, fpu_add_pkg::OP_ADD);
    end_test();

    begin_test("special");
    run_op(32'h40490FDB, 32'h40490FDB, fpu_add_pkg::OP_SUB);
    run_op(32'h00123456, 32'h3F800000, fpu_add_pkg::OP_ADD);
    run_op(32'h7F7FFFFF, 32'h7F7FFFFF, fpu_add_pkg::OP_ADD);
    run_op(32'hFF7FFFFF, 32'h7F7FFFFF, fpu_add_pkg::OP_SUB);
    run_op(32'h00800001, 32'h00800000, fpu_add_pkg::OP_SUB);
    end_test();

    // Second start lands while busy
    begin_test("busy_start");
    want = ref_add(32'h41200000, 32'h3E800000, fpu_add_pkg::OP_ADD);
    issue_op(32'h41200000, 32'h3E800000, fpu_add_pkg::OP_ADD);
    start_i <= 1'b1;
    a_i     <= 32'h42C80000;
    b_i     <= 32'h3F800000;
    op_i    <= fpu_add_pkg::OP_SUB;
    @(posedge clk);
    start_i <= 1'b0;
    wait_done();
    check_result(want);
    // No second result may follow
    repeat (8) @(negedge clk);
    check_result(want);
    end_test();

    // Nearby exponents favored so the adder paths all get hit
    begin_test("random");
    for (int n = 0; n < 200; n++) begin
      ea = 1 + int'($urandom % 254);
      eb = ea + int'($urandom % 25) - 12;
      if (eb < 1) eb = 1;
      if (eb > 254) eb = 254;
      ra  = {1'($urandom & 1), 8'(ea), 23'($urandom)};
      rb  = {1'($urandom & 1), 8'(eb), 23'($urandom)};
      rop = ($urandom & 1) ? fpu_add_pkg::OP_SUB : fpu_add_pkg::OP_ADD;
      run_op(ra, rb, rop);
    end
    end_test();

    $display("Tests %0d, checks %0d, failures %0d", tests_run, check_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== fpu_add.f ====
+incdir+.
fpu_add_pkg.sv
bidir_shifter.sv
exp_compare.sv
sig_addsub.sv
lead_zero_count.sv
fadd_sequencer.sv
fpu_add_top.sv
tb_fpu_add.sv

// ==== Makefile ====
# Verilator build and run for the float adder testbench

VERILATOR ?= verilator
TOP       ?= tb_fpu_add
DUT_TOP   ?= fpu_add_top
FLIST     ?= fpu_add.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  ?= All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(DUT_TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR)
